// File: hdl/ex_pkg.sv
// Execute stage types and codes. RV32M and MDV_ITER are fixed here and MDV_ITER must equal the word width
`default_nettype none

package ex_pkg;

  //////////////////////////////
  // Data widths
  //////////////////////////////

  // One register word
  typedef logic [31:0] word_t;
  // Adder operand with the carry-in slot at bit 0
  typedef logic [32:0] word_ext_t;
  // Adder sum with carry-in slot at bit 0 and carry-out at bit 33
  typedef logic [33:0] adder_ext_t;

  //////////////////////////////
  // ALU operation codes
  //////////////////////////////

  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_XOR  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_AND  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;
  // Branch comparisons
  localparam alu_op_t ALU_EQ   = 4'd10;
  localparam alu_op_t ALU_NE   = 4'd11;
  localparam alu_op_t ALU_LT   = 4'd12;
  localparam alu_op_t ALU_LTU  = 4'd13;
  localparam alu_op_t ALU_GE   = 4'd14;
  localparam alu_op_t ALU_GEU  = 4'd15;

  //////////////////////////////
  // Multiply and divide
  //////////////////////////////

  typedef logic [1:0] mdv_op_t;

  localparam mdv_op_t MDV_MUL  = 2'd0;
  localparam mdv_op_t MDV_MULH = 2'd1;
  localparam mdv_op_t MDV_DIV  = 2'd2;
  localparam mdv_op_t MDV_REM  = 2'd3;

  // Bit 0 marks operand a signed, bit 1 marks operand b signed
  typedef logic [1:0] mdv_sign_t;

  // RV32M present when 1
  localparam bit RV32M     = 1'b1;
  // Loop steps, one per result bit
  localparam int MDV_ITER  = 32;
  localparam int MDV_CNT_W = $clog2(MDV_ITER);

  typedef logic [MDV_CNT_W-1:0] mdv_cnt_t;

  // Requests from decode
  typedef struct packed {
    alu_op_t op;
    word_t   operand_a;
    word_t   operand_b;
  } alu_req_t;

  typedef struct packed {
    mdv_op_t   op;
    mdv_sign_t signed_mode;
    word_t     operand_a;
    word_t     operand_b;
  } mdv_req_t;

  // Multdiv sequencer
  typedef enum logic [2:0] {
    MDV_IDLE,
    MDV_ABS_A,
    MDV_ABS_B,
    MDV_LOOP,
    MDV_FIX,
    MDV_DONE
  } mdv_state_e;

endpackage

`default_nettype wire

// File: hdl/ex_alu.sv
// Single-cycle RV32 ALU. While mdv_en_i is high the adder serves the multdiv unit and results are meaningless
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
  input  ex_pkg::alu_req_t   alu_req_i,
  input  ex_pkg::word_ext_t  mdv_operand_a_i,
  input  ex_pkg::word_ext_t  mdv_operand_b_i,
  input  logic               mdv_en_i,
  output ex_pkg::word_t      adder_result_o,
  output ex_pkg::adder_ext_t adder_result_ext_o,
  output ex_pkg::word_t      result_o,
  output logic               comparison_result_o,
  output logic               is_equal_o
);

  import ex_pkg::*;

  alu_op_t   op;
  word_t     op_a;
  word_t     op_b;
  logic      adder_negate;
  word_ext_t adder_in_a;
  word_ext_t adder_in_b;
  logic      cmp_signed;
  logic      is_less;
  logic      shift_left;
  logic      shift_arith;
  word_t     shift_src;
  word_ext_t shift_ext;
  word_ext_t shift_wide;
  word_t     shift_res;

  // Unpack the request
  assign op   = alu_req_i.op;
  assign op_a = alu_req_i.operand_a;
  assign op_b = alu_req_i.operand_b;

  //////////////////////////////
  // Shared adder
  //////////////////////////////

  // Subtract for SUB and every compare
  assign adder_negate = op inside {ALU_SUB, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
                                   ALU_LT, ALU_LTU, ALU_GE, ALU_GEU};

  // Bit 0 of both operands forms the carry-in
  // a gets a 1 there so an inverted b turns into a two's complement
  assign adder_in_a = mdv_en_i ? mdv_operand_a_i : {op_a, 1'b1};
  assign adder_in_b = mdv_en_i ? mdv_operand_b_i
                               : ({op_b, 1'b0} ^ {33{adder_negate}});

  // Full 34 bit sum keeps the carry out for the divider
  assign adder_result_ext_o = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign adder_result_o     = adder_result_ext_o[32:1];

  // Zero flag of the raw sum
  // a == b for compares, divisor zero check for multdiv
  assign is_equal_o = (adder_result_o == '0);

  //////////////////////////////
  // Comparisons
  //////////////////////////////

  assign cmp_signed = op inside {ALU_SLT, ALU_LT, ALU_GE};

  always_comb begin
    // Different MSBs decide without the adder
    if (op_a[31] ^ op_b[31]) begin
      is_less = cmp_signed ? op_a[31] : op_b[31];
    end else begin
      // Same MSBs so a - b cannot overflow
      is_less = adder_result_o[31];
    end
  end

  always_comb begin
    unique case (op)
      ALU_EQ:                              comparison_result_o = is_equal_o;
      ALU_NE:                              comparison_result_o = ~is_equal_o;
      ALU_SLT, ALU_SLTU, ALU_LT, ALU_LTU:  comparison_result_o = is_less;
      ALU_GE, ALU_GEU:                     comparison_result_o = ~is_less;
      default:                             comparison_result_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Shifter
  //////////////////////////////

  assign shift_left  = (op == ALU_SLL);
  assign shift_arith = (op == ALU_SRA);

  // Left shift done as right shift of the reversed operand
  always_comb begin
    shift_src = op_a;
    if (shift_left) begin
      shift_src = {<<{op_a}};
    end
  end

  // Extra MSB carries the sign for SRA
  assign shift_ext  = {shift_arith & op_a[31], shift_src};
  assign shift_wide = $signed(shift_ext) >>> op_b[4:0];

  // Undo the reversal for SLL
  always_comb begin
    shift_res = shift_wide[31:0];
    if (shift_left) begin
      shift_res = {<<{shift_wide[31:0]}};
    end
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    unique case (op)
      ALU_ADD, ALU_SUB:           result_o = adder_result_o;
      ALU_XOR:                    result_o = op_a ^ op_b;
      ALU_OR:                     result_o = op_a | op_b;
      ALU_AND:                    result_o = op_a & op_b;
      ALU_SLL, ALU_SRL, ALU_SRA:  result_o = shift_res;
      // Set-less-than and branch codes return the flag in bit 0
      default:                    result_o = {{31{1'b0}}, comparison_result_o};
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/ex_multdiv_iter.sv
// Iterative multiply/divide borrowing the ALU adder. mdv_req_i must stay stable while mdv_en_i is high
`timescale 1ns/10ps
`default_nettype none

module ex_multdiv_iter (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               mdv_en_i,
  input  ex_pkg::mdv_req_t   mdv_req_i,
  input  ex_pkg::word_t      alu_adder_i,
  input  ex_pkg::adder_ext_t alu_adder_ext_i,
  input  logic               equal_to_zero_i,
  output logic               ready_o,
  output ex_pkg::word_ext_t  alu_operand_a_o,
  output ex_pkg::word_ext_t  alu_operand_b_o,
  output ex_pkg::word_t      result_o
);

  import ex_pkg::*;

  // Control
  mdv_state_e state_q;
  mdv_state_e state_d;
  mdv_cnt_t   cnt_q;

  // Operands and partial results
  mdv_op_t   op_q;
  word_t     opa_q;
  word_t     opb_q;
  word_t     acc_q;
  word_t     result_q;
  logic      a_neg_q;
  logic      b_neg_q;
  logic      neg_q;

  logic      is_div;
  logic      div_by_zero;
  logic      last_iter;
  word_ext_t rem_shift;
  logic      quot_bit;
  word_t     fix_val;
  logic      fix_cin;

  assign is_div    = op_q inside {MDV_DIV, MDV_REM};
  assign last_iter = (cnt_q == '0);

  // In ABS_B the adder holds -b so zero means b is zero
  assign div_by_zero = is_div & equal_to_zero_i;

  // Restoring divide
  // opa_q shifts the dividend out at the top and takes quotient bits at the bottom
  assign rem_shift = {acc_q, opa_q[31]};
  // A set bit 32 already exceeds any divisor
  assign quot_bit  = rem_shift[32] | alu_adder_ext_i[33];

  // High half for MULH and REM, low half otherwise
  assign fix_val = (op_q inside {MDV_MULH, MDV_REM}) ? acc_q : opa_q;
  // Negating the high half only carries in when the low half is zero
  assign fix_cin = (op_q == MDV_MULH) ? (opa_q == '0) : 1'b1;

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MDV_IDLE: begin
        if (mdv_en_i) begin
          state_d = MDV_ABS_A;
        end
      end
      MDV_ABS_A: state_d = MDV_ABS_B;
      // Division by zero jumps straight to the fix step
      MDV_ABS_B: state_d = div_by_zero ? MDV_FIX : MDV_LOOP;
      MDV_LOOP: begin
        if (last_iter) begin
          state_d = MDV_FIX;
        end
      end
      MDV_FIX:   state_d = MDV_DONE;
      MDV_DONE:  state_d = MDV_IDLE;
      default:   state_d = MDV_IDLE;
    endcase
    // Dropped enable abandons the operation
    if (!mdv_en_i) begin
      state_d = MDV_IDLE;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= MDV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == MDV_ABS_B) begin
        cnt_q <= mdv_cnt_t'(MDV_ITER - 1);
      end else if (state_q == MDV_LOOP && !last_iter) begin
        cnt_q <= cnt_q - mdv_cnt_t'(1);
      end
    end
  end

  //////////////////////////////
  // Adder side path
  //////////////////////////////

  always_comb begin
    alu_operand_a_o = '0;
    alu_operand_b_o = '0;
    unique case (state_q)
      // Two's complement of a
      MDV_ABS_A: begin
        alu_operand_a_o = {~opa_q, 1'b1};
        alu_operand_b_o = word_ext_t'(1);
      end
      MDV_ABS_B: begin
        alu_operand_a_o = {~opb_q, 1'b1};
        alu_operand_b_o = word_ext_t'(1);
      end
      MDV_LOOP: begin
        if (is_div) begin
          // Trial subtract of the divisor
          alu_operand_a_o = {rem_shift[31:0], 1'b1};
          alu_operand_b_o = {~opb_q, 1'b1};
        end else begin
          // Add multiplicand when the multiplier LSB is set
          alu_operand_a_o = {acc_q, 1'b0};
          alu_operand_b_o = {opb_q & {32{opa_q[0]}}, 1'b0};
        end
      end
      // Invert and add carry
      MDV_FIX: begin
        alu_operand_a_o = {~fix_val, 1'b1};
        alu_operand_b_o = word_ext_t'(fix_cin);
      end
      default: ;
    endcase
  end

  //////////////////////////////
  // Datapath registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    unique case (state_q)
      // Capture the request every idle cycle
      MDV_IDLE: begin
        op_q    <= mdv_req_i.op;
        opa_q   <= mdv_req_i.operand_a;
        opb_q   <= mdv_req_i.operand_b;
        a_neg_q <= mdv_req_i.signed_mode[0] & mdv_req_i.operand_a[31];
        b_neg_q <= mdv_req_i.signed_mode[1] & mdv_req_i.operand_b[31];
        acc_q   <= '0;
      end
      MDV_ABS_A: begin
        if (a_neg_q) begin
          opa_q <= alu_adder_i;
        end
      end
      MDV_ABS_B: begin
        if (b_neg_q) begin
          opb_q <= alu_adder_i;
        end
        // Remainder follows the dividend sign
        if (op_q == MDV_REM) begin
          neg_q <= a_neg_q;
        end else begin
          neg_q <= (a_neg_q ^ b_neg_q) & ~div_by_zero;
        end
        // All-ones quotient and the dividend as remainder
        if (div_by_zero) begin
          acc_q <= opa_q;
          opa_q <= '1;
        end
      end
      MDV_LOOP: begin
        if (is_div) begin
          acc_q <= quot_bit ? alu_adder_ext_i[32:1] : rem_shift[31:0];
          opa_q <= {opa_q[30:0], quot_bit};
        end else begin
          // Sum and carry shift right into the product
          acc_q <= alu_adder_ext_i[33:2];
          opa_q <= {alu_adder_ext_i[1], opa_q[31:1]};
        end
      end
      MDV_FIX: result_q <= neg_q ? alu_adder_i : fix_val;
      default: ;
    endcase
  end

  assign ready_o  = (state_q == MDV_DONE);
  assign result_o = result_q;

endmodule

`default_nettype wire

// File: hdl/ex_block.sv
// Execute stage top. Decode holds at most one enable and keeps it until ex_ready_o is seen high
`timescale 1ns/10ps
`default_nettype none

module ex_block (
  input  logic             clk,
  input  logic             arst_n_i,
  input  ex_pkg::alu_req_t alu_req_i,
  input  ex_pkg::mdv_req_t mdv_req_i,
  input  logic             mult_en_i,
  input  logic             div_en_i,
  input  logic             lsu_en_i,
  input  logic             lsu_ready_i,
  output ex_pkg::word_t    alu_adder_result_o,
  output ex_pkg::word_t    wdata_o,
  output ex_pkg::word_t    jump_target_o,
  output logic             branch_decision_o,
  output logic             ex_ready_o
);

  import ex_pkg::*;

  word_t      alu_result;
  word_t      mdv_result;
  word_ext_t  mdv_operand_a;
  word_ext_t  mdv_operand_b;
  adder_ext_t alu_adder_ext;
  logic       alu_cmp;
  logic       alu_is_equal;
  logic       mdv_ready;
  logic       mdv_en;

  // Without RV32M the enable is tied low and the unit never leaves idle
  if (RV32M) begin : g_mdv_on
    assign mdv_en = mult_en_i | div_en_i;
  end else begin : g_mdv_off
    assign mdv_en = 1'b0;
  end

  // Write-back select
  assign wdata_o = mdv_en ? mdv_result : alu_result;

  // Branch outcome and jump target straight from the ALU
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_adder_result_o;

  //////////////////////////////
  // ALU
  //////////////////////////////

  ex_alu alu0 (
    .alu_req_i           (alu_req_i),
    .mdv_operand_a_i     (mdv_operand_a),
    .mdv_operand_b_i     (mdv_operand_b),
    .mdv_en_i            (mdv_en),
    .adder_result_o      (alu_adder_result_o),
    .adder_result_ext_o  (alu_adder_ext),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp),
    .is_equal_o          (alu_is_equal)
  );

  //////////////////////////////
  // Multiply / divide
  //////////////////////////////

  ex_multdiv_iter mdv0 (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .mdv_en_i        (mdv_en),
    .mdv_req_i       (mdv_req_i),
    .alu_adder_i     (alu_adder_result_o),
    .alu_adder_ext_i (alu_adder_ext),
    .equal_to_zero_i (alu_is_equal),
    .ready_o         (mdv_ready),
    .alu_operand_a_o (mdv_operand_a),
    .alu_operand_b_o (mdv_operand_b),
    .result_o        (mdv_result)
  );

  // Stall control
  // Multdiv first, then a pending load/store, else single cycle
  always_comb begin
    if (mdv_en) begin
      ex_ready_o = mdv_ready;
    end else if (lsu_en_i) begin
      ex_ready_o = lsu_ready_i;
    end else begin
      ex_ready_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: test/ex_block_properties.sv
// Bound into ex_block. Checks are off in reset and the idle check fires at reset release
`timescale 1ns/10ps
`default_nettype none

module ex_block_properties (
  input logic               clk,
  input logic               arst_n_i,
  input logic               mult_en_i,
  input logic               div_en_i,
  input logic               lsu_en_i,
  input logic               ex_ready_i,
  input ex_pkg::mdv_state_e mdv_state_i
);

  import ex_pkg::*;

  // Count of assertion failures
  int fail_cnt = 0;

  //////////////////////////////
  // Enable and ready rules
  //////////////////////////////

  // Decode never asks for both units
  a_en_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(mult_en_i && div_en_i))
    else begin
      fail_cnt++;
      $error("mult_en_i and div_en_i high together");
    end

  // Nothing pending means no stall
  a_ready_free: assert property (@(posedge clk) disable iff (!arst_n_i)
    (!mult_en_i && !div_en_i && !lsu_en_i) |-> ex_ready_i)
    else begin
      fail_cnt++;
      $error("ex_ready_o low with no enable high");
    end

  // Sequencer starts idle
  a_idle_reset: assert property (@(posedge clk)
    $rose(arst_n_i) |-> (mdv_state_i == MDV_IDLE))
    else begin
      fail_cnt++;
      $error("multdiv state not idle after reset");
    end

endmodule

bind ex_block ex_block_properties props0 (
  .clk         (clk),
  .arst_n_i    (arst_n_i),
  .mult_en_i   (mult_en_i),
  .div_en_i    (div_en_i),
  .lsu_en_i    (lsu_en_i),
  .ex_ready_i  (ex_ready_o),
  .mdv_state_i (mdv0.state_q)
);

`default_nettype wire

// File: test/ex_block_checker.sv
// Compares on rising edges out of reset. ALU outputs are checked only with no multdiv enable
`timescale 1ns/10ps
`default_nettype none

module ex_block_checker (
  input  logic             clk,
  input  logic             arst_n_i,
  input  ex_pkg::alu_req_t alu_req_i,
  input  ex_pkg::mdv_req_t mdv_req_i,
  input  logic             mult_en_i,
  input  logic             div_en_i,
  input  logic             lsu_en_i,
  input  logic             lsu_ready_i,
  input  ex_pkg::word_t    alu_adder_result_i,
  input  ex_pkg::word_t    wdata_i,
  input  ex_pkg::word_t    jump_target_i,
  input  logic             branch_decision_i,
  input  logic             ex_ready_i,
  output int               err_cnt_o,
  output int               chk_cnt_o
);

  import ex_pkg::*;

  int    err_cnt = 0;
  int    chk_cnt = 0;
  // Rising edges seen with an enable high and ready low
  int    busy_cnt = 0;
  word_t exp_val;
  logic  exp_rdy;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Branch flag per RISC-V compare rules
  function automatic logic cmp_ref(alu_op_t op, word_t a, word_t b);
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_ref(alu_op_t op, word_t a, word_t b);
    word_t sra;
    sra = $signed(a) >>> b[4:0];
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_XOR: return a ^ b;
      ALU_OR:  return a | b;
      ALU_AND: return a & b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return sra;
      // Set-less-than and branch codes give the flag in bit 0
      default: return {31'b0, cmp_ref(op, a, b)};
    endcase
  endfunction

  // Raw adder sum is a - b for SUB and every compare
  function automatic word_t sum_ref(alu_op_t op, word_t a, word_t b);
    return (op inside {ALU_ADD, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA}) ?
           a + b : a - b;
  endfunction

  function automatic word_t mdv_ref(mdv_op_t op, mdv_sign_t sm, word_t a, word_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    logic        na;
    logic        nb;
    word_t       ma;
    word_t       mb;
    na   = sm[0] & a[31];
    nb   = sm[1] & b[31];
    ea   = na ? {32'hffff_ffff, a} : {32'h0, a};
    eb   = nb ? {32'hffff_ffff, b} : {32'h0, b};
    prod = ea * eb;
    // Magnitudes for truncating division
    ma   = na ? -a : a;
    mb   = nb ? -b : b;
    case (op)
      MDV_MUL:  return prod[31:0];
      MDV_MULH: return prod[63:32];
      MDV_DIV: begin
        if (b == '0) begin
          return '1;
        end
        // Signed overflow keeps the dividend
        if (sm == 2'b11 && a == 32'h8000_0000 && b == '1) begin
          return a;
        end
        return (na ^ nb) ? -(ma / mb) : ma / mb;
      end
      default: begin
        if (b == '0) begin
          return a;
        end
        if (sm == 2'b11 && a == 32'h8000_0000 && b == '1) begin
          return '0;
        end
        // Remainder takes the sign of the dividend
        return na ? -(ma % mb) : ma % mb;
      end
    endcase
  endfunction

  task automatic report_fail(string what, word_t got, word_t exp);
    err_cnt++;
    $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  //////////////////////////////
  // Compare at rising edges
  //////////////////////////////

  always @(posedge clk) begin
    if (arst_n_i) begin
      if (mult_en_i || div_en_i) begin
        if (!ex_ready_i) begin
          busy_cnt++;
        end else begin
          chk_cnt++;
          exp_val = mdv_ref(mdv_req_i.op, mdv_req_i.signed_mode,
                            mdv_req_i.operand_a, mdv_req_i.operand_b);
          if (wdata_i !== exp_val) begin
            report_fail("multdiv wdata_o", wdata_i, exp_val);
          end
          if (busy_cnt > MDV_ITER + 4) begin
            err_cnt++;
            $display("ERROR at %0t: multiply/divide needed %0d cycles, more than the bound",
                     $time, busy_cnt);
          end
          busy_cnt = 0;
        end
      end else begin
        busy_cnt = 0;
        // A pending LSU stalls and anything else is single cycle
        exp_rdy = lsu_en_i ? lsu_ready_i : 1'b1;
        if (ex_ready_i !== exp_rdy) begin
          err_cnt++;
          $display("FAIL %0t: ex_ready_o is %b, expected %b", $time, ex_ready_i, exp_rdy);
        end
        if (ex_ready_i) begin
          chk_cnt++;
          exp_val = alu_ref(alu_req_i.op, alu_req_i.operand_a, alu_req_i.operand_b);
          if (wdata_i !== exp_val) begin
            report_fail("ALU wdata_o", wdata_i, exp_val);
          end
          exp_val = word_t'(cmp_ref(alu_req_i.op, alu_req_i.operand_a, alu_req_i.operand_b));
          if (word_t'(branch_decision_i) !== exp_val) begin
            report_fail("branch_decision_o", word_t'(branch_decision_i), exp_val);
          end
          exp_val = sum_ref(alu_req_i.op, alu_req_i.operand_a, alu_req_i.operand_b);
          if (jump_target_i !== exp_val) begin
            report_fail("jump_target_o", jump_target_i, exp_val);
          end
          if (alu_adder_result_i !== exp_val) begin
            report_fail("alu_adder_result_o", alu_adder_result_i, exp_val);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/ex_block_tb.sv
// Seed 40 stimulus on falling edges. Each ready wait gives up after MDV_ITER+10 cycles
`timescale 1ns/10ps
`default_nettype none

module ex_block_tb;

  import ex_pkg::*;

  localparam int TIMEOUT = MDV_ITER + 10;

  logic     clk;
  logic     arst_n;
  alu_req_t alu_req;
  mdv_req_t mdv_req;
  logic     mult_en;
  logic     div_en;
  logic     lsu_en;
  logic     lsu_ready;
  word_t    alu_adder_result;
  word_t    wdata;
  word_t    jump_target;
  logic     branch_decision;
  logic     ex_ready;

  integer   seed = 40;
  int       tb_err = 0;
  int       chk_err;
  int       chk_cnt;
  int       test_cnt = 0;
  int       err_mark = 0;

  ex_block dut0 (
    .clk                (clk),
    .arst_n_i           (arst_n),
    .alu_req_i          (alu_req),
    .mdv_req_i          (mdv_req),
    .mult_en_i          (mult_en),
    .div_en_i           (div_en),
    .lsu_en_i           (lsu_en),
    .lsu_ready_i        (lsu_ready),
    .alu_adder_result_o (alu_adder_result),
    .wdata_o            (wdata),
    .jump_target_o      (jump_target),
    .branch_decision_o  (branch_decision),
    .ex_ready_o         (ex_ready)
  );

  ex_block_checker chk0 (
    .clk                (clk),
    .arst_n_i           (arst_n),
    .alu_req_i          (alu_req),
    .mdv_req_i          (mdv_req),
    .mult_en_i          (mult_en),
    .div_en_i           (div_en),
    .lsu_en_i           (lsu_en),
    .lsu_ready_i        (lsu_ready),
    .alu_adder_result_i (alu_adder_result),
    .wdata_i            (wdata),
    .jump_target_i      (jump_target),
    .branch_decision_i  (branch_decision),
    .ex_ready_i         (ex_ready),
    .err_cnt_o          (chk_err),
    .chk_cnt_o          (chk_cnt)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic int total_errors();
    return tb_err + chk_err + dut0.props0.fail_cnt;
  endfunction

  // New ALU request with a quarter of them using equal operands
  task automatic rand_alu();
    alu_req.op        = alu_op_t'(rand_word());
    alu_req.operand_a = rand_word();
    alu_req.operand_b = rand_word();
    if ((rand_word() & 32'h3) == '0) begin
      alu_req.operand_b = alu_req.operand_a;
    end
  endtask

  // Ready is read on falling edges away from the rising edge
  task automatic wait_ready();
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      if (ex_ready) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!seen) begin
      tb_err++;
      $display("ERROR at %0t: ex_ready_o did not rise within %0d cycles", $time, TIMEOUT);
    end
  endtask

  // One multiply or divide with the enable held until ready is seen
  task automatic run_mdv(mdv_op_t op, mdv_sign_t sm, word_t a, word_t b);
    @(negedge clk);
    rand_alu();
    mdv_req.op          = op;
    mdv_req.signed_mode = sm;
    mdv_req.operand_a   = a;
    mdv_req.operand_b   = b;
    mult_en = (op == MDV_MUL) || (op == MDV_MULH);
    div_en  = ~mult_en;
    wait_ready();
    @(negedge clk);
    mult_en = 1'b0;
    div_en  = 1'b0;
  endtask

  task automatic test_done(string name, int ops);
    test_cnt++;
    $display("test %0d %s: %0d ops, %0d errors", test_cnt, name, ops,
             total_errors() - err_mark);
    err_mark = total_errors();
  endtask

  initial begin
    int        n;
    int        stall;
    mdv_op_t   op;
    mdv_sign_t sm;
    word_t     a;
    word_t     b;
    arst_n    = 1'b0;
    alu_req   = '0;
    mdv_req   = '0;
    mult_en   = 1'b0;
    div_en    = 1'b0;
    lsu_en    = 1'b0;
    lsu_ready = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Single-cycle ALU over all codes
    for (n = 0; n < 300; n++) begin
      @(negedge clk);
      rand_alu();
    end
    @(negedge clk);
    test_done("alu_random", 300);

    for (n = 0; n < 60; n++) begin
      op = ((rand_word() & 32'h1) != '0) ? MDV_MULH : MDV_MUL;
      sm = mdv_sign_t'(rand_word());
      a  = rand_word();
      b  = rand_word();
      run_mdv(op, sm, a, b);
    end
    test_done("mul_random", 60);

    // Divisors of varied size so quotients are not always tiny
    for (n = 0; n < 60; n++) begin
      op = ((rand_word() & 32'h1) != '0) ? MDV_REM : MDV_DIV;
      sm = mdv_sign_t'(rand_word());
      a  = rand_word();
      b  = rand_word() >> (rand_word() & 32'h1f);
      run_mdv(op, sm, a, b);
    end
    test_done("div_random", 60);

    // Divide by zero in every mode and then signed overflow
    for (n = 0; n < 8; n++) begin
      a = rand_word();
      run_mdv(n[0] ? MDV_REM : MDV_DIV, mdv_sign_t'(n >> 1), a, '0);
    end
    run_mdv(MDV_DIV, 2'b11, 32'h8000_0000, '1);
    run_mdv(MDV_REM, 2'b11, 32'h8000_0000, '1);
    test_done("div_corner", 10);

    // Pending load/store holds ready low until lsu_ready_i
    for (n = 0; n < 20; n++) begin
      stall = 1 + (rand_word() & 32'h7);
      @(negedge clk);
      rand_alu();
      lsu_en    = 1'b1;
      lsu_ready = 1'b0;
      repeat (stall) @(negedge clk);
      lsu_ready = 1'b1;
      wait_ready();
      @(negedge clk);
      lsu_en    = 1'b0;
      lsu_ready = 1'b0;
    end
    test_done("lsu_stall", 20);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_multdiv_iter.sv
hdl/ex_block.sv
test/ex_block_properties.sv
test/ex_block_checker.sv
test/ex_block_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ex_block testbench with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module ex_block_tb -f vlog.f \
  && ./obj_dir/Vex_block_tb > sim.log 2>&1 \
  || echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^Test completed successfully$" sim.log 2>/dev/null \
  && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }
